// ==== pcap_replay.f ====
hw/replay_pkg.sv
hw/ingress_fifo.sv
hw/replay_mem.sv
hw/queue_writer.sv
hw/queue_reader.sv
hw/pcap_replay_top.sv
sim/pcap_replay_sva.sv
sim/tb_pcap_replay.sv

// ==== Makefile ====
# Verilator build and run of the replay engine testbench

SIM  := obj_dir/Vtb_pcap_replay
SRCS := $(shell cat pcap_replay.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): pcap_replay.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_pcap_replay -f pcap_replay.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== sim/replay_patterns.txt ====
# Commands: W qid last data | I cycles | R qid | E qid data | M qid
# qid, last and cycles in decimal, data in hex, one packet or request group per line
# Every queue misses while empty
R 0 M 0 R 1 M 1 R 2 M 2 R 3 M 3
# Interleaved packets to all four queues
W 0 0 a000 W 0 1 a001
W 1 1 b000
W 2 0 c000 W 2 0 c001 W 2 1 c002
W 3 1 d000
W 1 0 b001 W 1 1 b002
I 12
R 1 E 1 b000 R 1 E 1 b001 R 1 E 1 b002 R 1 M 1
R 3 E 3 d000 R 3 M 3
R 0 E 0 a000 R 0 E 0 a001 R 0 M 0
R 2 E 2 c000 R 2 E 2 c001 R 2 E 2 c002 R 2 M 2
# Queue 2 fills to 14 words across its ring end, the next packet is dropped
W 2 0 c010 W 2 0 c011 W 2 0 c012 W 2 1 c013
W 2 0 c020 W 2 0 c021 W 2 0 c022 W 2 1 c023
W 2 0 c030 W 2 0 c031 W 2 0 c032 W 2 1 c033
W 2 0 c040 W 2 1 c041
W 2 0 c050 W 2 0 c051 W 2 1 c052
W 1 0 b010 W 1 1 b011
I 15
R 2 E 2 c010 R 2 E 2 c011 R 2 E 2 c012 R 2 E 2 c013
R 2 E 2 c020 R 2 E 2 c021 R 2 E 2 c022 R 2 E 2 c023
R 2 E 2 c030 R 2 E 2 c031 R 2 E 2 c032 R 2 E 2 c033
R 2 E 2 c040 R 2 E 2 c041 R 2 M 2
R 1 E 1 b010 R 1 E 1 b011 R 1 M 1
# Burst of 16 words with no idle cycles, twice the FIFO depth
W 0 0 e000 W 0 0 e001 W 0 0 e002 W 0 1 e003
W 3 0 f000 W 3 0 f001 W 3 0 f002 W 3 1 f003
W 0 0 e010 W 0 0 e011 W 0 0 e012 W 0 1 e013
W 0 0 e020 W 0 0 e021 W 0 0 e022 W 0 1 e023
I 20
R 0 E 0 e000 R 0 E 0 e001 R 0 E 0 e002 R 0 E 0 e003
R 0 E 0 e010 R 0 E 0 e011 R 0 E 0 e012 R 0 E 0 e013
R 0 E 0 e020 R 0 E 0 e021 R 0 E 0 e022 R 0 E 0 e023 R 0 M 0
R 3 E 3 f000 R 3 E 3 f001 R 3 E 3 f002 R 3 E 3 f003 R 3 M 3
# Queue 0 wraps past the end of its ring
W 0 0 e030 W 0 0 e031 W 0 0 e032 W 0 1 e033
I 12
R 0 E 0 e030 R 0 E 0 e031 R 0 E 0 e032 R 0 E 0 e033 R 0 M 0

// ==== sim/tb_pcap_replay.sv ====
/*
 * Replay engine testbench
 * Runs the command patterns from a text file against the DUT and
 * checks every replay result in request order
 */
`timescale 1ns/1ns

module tb_pcap_replay;

  localparam int    DATA_WIDTH      = 64;
  localparam int    QID_BITS        = replay_pkg::QID_BITS;
  localparam int    EXP_BITS        = 1 + QID_BITS + DATA_WIDTH;
  localparam int    CYCLES_PER_LINE = 200;
  localparam string PATTERN_FILE    = "sim/replay_patterns.txt";

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  logic [DATA_WIDTH-1:0] in_data;
  logic [QID_BITS-1:0]   in_qid;
  logic                  in_last;
  logic                  in_ready;
  logic                  rd_req;
  logic [QID_BITS-1:0]   rd_qid;
  logic                  out_valid;
  logic                  out_miss;
  logic [QID_BITS-1:0]   out_qid;
  logic [DATA_WIDTH-1:0] out_data;

  // Expected results as {miss, qid, data}, oldest first
  logic [EXP_BITS-1:0] exp_q [$];
  logic [EXP_BITS-1:0] exp_item;
  int                  num_lines = 0;

  pcap_replay_top #(
    .DATA_WIDTH     (DATA_WIDTH),
    .QUEUE_ADDR_BITS(4),
    .MAX_PKT_WORDS  (4),
    .FIFO_ADDR_BITS (3)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_data  (in_data),
    .in_qid   (in_qid),
    .in_last  (in_last),
    .in_ready (in_ready),
    .rd_req   (rd_req),
    .rd_qid   (rd_qid),
    .out_valid(out_valid),
    .out_miss (out_miss),
    .out_qid  (out_qid),
    .out_data (out_data)
  );

  always #10 clk = ~clk;

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Testbench stopped on error");
  endtask

  task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] expected);
    if (got !== expected) begin
      stop_run($sformatf("Mismatch at %0t ns: %s is %0h, expected %0h",
                         $time, what, got, expected));
    end
  endtask

  // All drives happen 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic push_word(input int q, input int last_flag,
                           input logic [DATA_WIDTH-1:0] data);
    while (!in_ready) begin
      next_cycle();
    end
    in_valid = 1'b1;
    in_qid   = q[QID_BITS-1:0];
    in_last  = last_flag[0];
    in_data  = data;
    next_cycle();
    in_valid = 1'b0;
  endtask

  task automatic request_word(input int q);
    rd_req = 1'b1;
    rd_qid = q[QID_BITS-1:0];
    next_cycle();
    rd_req = 1'b0;
  endtask

  task automatic count_lines();
    int               fd;
    int               code;
    logic [8*128-1:0] line_buf;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      stop_run("Cannot open the pattern file");
    end
    while (!$feof(fd)) begin
      code = $fgets(line_buf, fd);
      if (code > 0) begin
        num_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_patterns();
    int                    fd;
    int                    code;
    int                    q;
    int                    num;
    int                    last_flag;
    logic [7:0]            cmd;
    logic [DATA_WIDTH-1:0] data;
    logic [8*128-1:0]      line_buf;
    logic                  done;
    fd = $fopen(PATTERN_FILE, "r");
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        case (cmd)
          "#": code = $fgets(line_buf, fd);
          "W": begin
            code = $fscanf(fd, "%d %d %h", q, last_flag, data);
            push_word(q, last_flag, data);
          end
          "I": begin
            code = $fscanf(fd, "%d", num);
            repeat (num) next_cycle();
          end
          "R": begin
            code = $fscanf(fd, "%d", q);
            request_word(q);
          end
          "E": begin
            code = $fscanf(fd, "%d %h", q, data);
            exp_q.push_back({1'b0, q[QID_BITS-1:0], data});
          end
          "M": begin
            code = $fscanf(fd, "%d", q);
            exp_q.push_back({1'b1, q[QID_BITS-1:0], {DATA_WIDTH{1'b0}}});
          end
          default: stop_run($sformatf("Unknown command %s in the pattern file", cmd));
        endcase
      end
    end
    $fclose(fd);
  endtask

  // Each result takes the oldest expectation
  always @(negedge clk) begin
    if (!rst && (out_valid || out_miss)) begin
      if (exp_q.size() == 0) begin
        stop_run("A replay result arrived with no expected result waiting");
      end else begin
        exp_item = exp_q.pop_front();
        check_value("out_valid", DATA_WIDTH'(out_valid), DATA_WIDTH'(!exp_item[EXP_BITS-1]));
        check_value("out_miss", DATA_WIDTH'(out_miss), DATA_WIDTH'(exp_item[EXP_BITS-1]));
        check_value("out_qid", DATA_WIDTH'(out_qid), DATA_WIDTH'(exp_item[DATA_WIDTH +: QID_BITS]));
        if (!exp_item[EXP_BITS-1]) begin
          check_value("out_data", out_data, exp_item[DATA_WIDTH-1:0]);
        end
      end
    end
  end

  initial begin
    wait (num_lines != 0);
    repeat (num_lines * CYCLES_PER_LINE) @(posedge clk);
    stop_run($sformatf("Timeout: no end after %0d cycles for %0d pattern lines",
                       num_lines * CYCLES_PER_LINE, num_lines));
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    in_valid = 1'b0;
    in_data  = '0;
    in_qid   = '0;
    in_last  = 1'b0;
    rd_req   = 1'b0;
    rd_qid   = '0;
    count_lines();
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    // FIFO comes out of reset empty
    check_value("in_ready", DATA_WIDTH'(in_ready), DATA_WIDTH'(1'b1));
    run_patterns();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    // A few more cycles to catch a result nobody asked for
    repeat (4) next_cycle();
    // Every accepted word has left the FIFO by now
    check_value("in_ready", DATA_WIDTH'(in_ready), DATA_WIDTH'(1'b1));
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== sim/pcap_replay_sva.sv ====
/*
 * Replay engine assertions
 * Result exclusivity, request latency, input handshake and writer FSM
 */
`timescale 1ns/1ns

module pcap_replay_sva (
  input logic                      clk,
  input logic                      rst,
  input logic                      in_valid,
  input logic                      in_ready,
  input logic                      rd_req,
  input logic                      out_valid,
  input logic                      out_miss,
  input logic                      fifo_rd_en,
  input logic                      fifo_last,
  input replay_pkg::writer_state_e writer_state
);

  a_result_excl: assert property (@(posedge clk) disable iff (rst)
    !(out_valid && out_miss))
    else $error("out_valid and out_miss high together");

  // Fixed two-cycle answer, data or miss but never both
  a_req_answer: assert property (@(posedge clk) disable iff (rst)
    rd_req |-> ##2 (out_valid ^ out_miss))
    else $error("rd_req without a single answer two cycles later");

  a_in_handshake: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> in_ready)
    else $error("in_valid while in_ready is low");

  // Admit or drop holds from the first word up to the popped last word
  a_decision_held: assert property (@(posedge clk) disable iff (rst)
    ((writer_state != replay_pkg::W_IDLE) && !(fifo_rd_en && fifo_last))
      |=> (writer_state == $past(writer_state)))
    else $error("Writer changed its admit or drop state inside a packet");

endmodule

bind pcap_replay_top pcap_replay_sva u_replay_sva (
  .clk         (clk),
  .rst         (rst),
  .in_valid    (in_valid),
  .in_ready    (in_ready),
  .rd_req      (rd_req),
  .out_valid   (out_valid),
  .out_miss    (out_miss),
  .fifo_rd_en  (fifo_rd_en),
  .fifo_last   (fifo_last),
  .writer_state(u_queue_writer.state)
);

// ==== hw/pcap_replay_top.sv ====
/*
 * Packet capture replay engine
 * Ingress FIFO, queue writer, shared ring memory and replay reader
 */
`timescale 1ns/1ns

module pcap_replay_top #(
  parameter int DATA_WIDTH      = 64,
  parameter int QUEUE_ADDR_BITS = 4,
  parameter int MAX_PKT_WORDS   = 4,
  parameter int FIFO_ADDR_BITS  = 3
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_valid,
  input  logic [DATA_WIDTH-1:0]           in_data,
  input  logic [replay_pkg::QID_BITS-1:0] in_qid,
  input  logic                            in_last,
  output logic                            in_ready,
  input  logic                            rd_req,
  input  logic [replay_pkg::QID_BITS-1:0] rd_qid,
  output logic                            out_valid,
  output logic                            out_miss,
  output logic [replay_pkg::QID_BITS-1:0] out_qid,
  output logic [DATA_WIDTH-1:0]           out_data
);

  localparam int MEM_ADDR_BITS = replay_pkg::QID_BITS + QUEUE_ADDR_BITS;
  localparam int PTRS_BITS     = replay_pkg::NUM_QUEUES * (QUEUE_ADDR_BITS + 1);

  logic                            fifo_full;
  logic                            fifo_empty;
  logic                            fifo_rd_en;
  logic [DATA_WIDTH-1:0]           fifo_data;
  logic [replay_pkg::QID_BITS-1:0] fifo_qid;
  logic                            fifo_last;
  logic [PTRS_BITS-1:0]            heads;
  logic [PTRS_BITS-1:0]            tails;
  logic                            mem_we;
  logic [MEM_ADDR_BITS-1:0]        mem_waddr;
  logic [DATA_WIDTH-1:0]           mem_wdata;
  logic                            mem_re;
  logic [MEM_ADDR_BITS-1:0]        mem_raddr;
  logic [DATA_WIDTH-1:0]           mem_rdata;

  assign in_ready = !fifo_full;

  ingress_fifo #(
    .DATA_WIDTH    (DATA_WIDTH),
    .FIFO_ADDR_BITS(FIFO_ADDR_BITS)
  ) u_ingress_fifo (
    .clk    (clk),
    .rst    (rst),
    .wr_en  (in_valid),
    .wr_data(in_data),
    .wr_qid (in_qid),
    .wr_last(in_last),
    .full   (fifo_full),
    .rd_en  (fifo_rd_en),
    .rd_data(fifo_data),
    .rd_qid (fifo_qid),
    .rd_last(fifo_last),
    .empty  (fifo_empty)
  );

  queue_writer #(
    .DATA_WIDTH     (DATA_WIDTH),
    .QUEUE_ADDR_BITS(QUEUE_ADDR_BITS),
    .MAX_PKT_WORDS  (MAX_PKT_WORDS)
  ) u_queue_writer (
    .clk       (clk),
    .rst       (rst),
    .fifo_data (fifo_data),
    .fifo_qid  (fifo_qid),
    .fifo_last (fifo_last),
    .fifo_empty(fifo_empty),
    .fifo_rd_en(fifo_rd_en),
    .heads     (heads),
    .tails     (tails),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata)
  );

  replay_mem #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_BITS (MEM_ADDR_BITS)
  ) u_replay_mem (
    .clk  (clk),
    .we   (mem_we),
    .waddr(mem_waddr),
    .wdata(mem_wdata),
    .re   (mem_re),
    .raddr(mem_raddr),
    .rdata(mem_rdata)
  );

  queue_reader #(
    .DATA_WIDTH     (DATA_WIDTH),
    .QUEUE_ADDR_BITS(QUEUE_ADDR_BITS)
  ) u_queue_reader (
    .clk      (clk),
    .rst      (rst),
    .rd_req   (rd_req),
    .rd_qid   (rd_qid),
    .tails    (tails),
    .heads    (heads),
    .mem_re   (mem_re),
    .mem_raddr(mem_raddr),
    .mem_rdata(mem_rdata),
    .out_valid(out_valid),
    .out_miss (out_miss),
    .out_qid  (out_qid),
    .out_data (out_data)
  );

endmodule

// ==== hw/queue_reader.sv ====
/*
 * Queue reader
 * Answers replay requests with the next stored word or a miss,
 * two cycles after each request
 */
`timescale 1ns/1ns

module queue_reader #(
  parameter int DATA_WIDTH      = 64,
  parameter int QUEUE_ADDR_BITS = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            rd_req,
  input  logic [replay_pkg::QID_BITS-1:0] rd_qid,
  input  logic [replay_pkg::NUM_QUEUES*(QUEUE_ADDR_BITS+1)-1:0] tails,
  output logic [replay_pkg::NUM_QUEUES*(QUEUE_ADDR_BITS+1)-1:0] heads,
  output logic                            mem_re,
  output logic [replay_pkg::QID_BITS+QUEUE_ADDR_BITS-1:0] mem_raddr,
  input  logic [DATA_WIDTH-1:0]           mem_rdata,
  output logic                            out_valid,
  output logic                            out_miss,
  output logic [replay_pkg::QID_BITS-1:0] out_qid,
  output logic [DATA_WIDTH-1:0]           out_data
);

  localparam int PTR_BITS = QUEUE_ADDR_BITS + 1;

  logic [PTR_BITS-1:0]             head_q [replay_pkg::NUM_QUEUES];
  logic [PTR_BITS-1:0]             tail_sel;
  logic                            q_empty;
  logic                            s1_valid;
  logic                            s1_miss;
  logic [replay_pkg::QID_BITS-1:0] s1_qid;

  // Empty check against the committed tail of the requested queue
  assign tail_sel = tails[rd_qid*PTR_BITS +: PTR_BITS];
  assign q_empty  = (tail_sel == head_q[rd_qid]);

  assign mem_re    = rd_req && !q_empty;
  assign mem_raddr = {rd_qid, head_q[rd_qid][QUEUE_ADDR_BITS-1:0]};

  always_comb begin
    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      heads[q*PTR_BITS +: PTR_BITS] = head_q[q];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      s1_miss   <= 1'b0;
      out_valid <= 1'b0;
      out_miss  <= 1'b0;
      for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
        head_q[q] <= '0;
      end
    end else begin
      if (mem_re) begin
        head_q[rd_qid] <= head_q[rd_qid] + 1'b1;
      end
      // Stage 1 matches the memory read, stage 2 the output register
      s1_valid  <= mem_re;
      s1_miss   <= rd_req && q_empty;
      out_valid <= s1_valid;
      out_miss  <= s1_miss;
    end
  end

  always_ff @(posedge clk) begin
    s1_qid  <= rd_qid;
    out_qid <= s1_qid;
    if (s1_valid) begin
      out_data <= mem_rdata;
    end
  end

endmodule

// ==== hw/queue_writer.sv ====
/*
 * Queue writer
 * Admits or drops each packet from the ingress FIFO by the free space
 * of its queue, then stores admitted words into that queue's ring
 */
`timescale 1ns/1ns

module queue_writer #(
  parameter int DATA_WIDTH      = 64,
  parameter int QUEUE_ADDR_BITS = 4,
  parameter int MAX_PKT_WORDS   = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [DATA_WIDTH-1:0]           fifo_data,
  input  logic [replay_pkg::QID_BITS-1:0] fifo_qid,
  input  logic                            fifo_last,
  input  logic                            fifo_empty,
  output logic                            fifo_rd_en,
  input  logic [replay_pkg::NUM_QUEUES*(QUEUE_ADDR_BITS+1)-1:0] heads,
  output logic [replay_pkg::NUM_QUEUES*(QUEUE_ADDR_BITS+1)-1:0] tails,
  output logic                            mem_we,
  output logic [replay_pkg::QID_BITS+QUEUE_ADDR_BITS-1:0] mem_waddr,
  output logic [DATA_WIDTH-1:0]           mem_wdata
);

  localparam int PTR_BITS   = QUEUE_ADDR_BITS + 1;
  localparam int CNT_BITS   = QUEUE_ADDR_BITS + 2;
  localparam int RING_WORDS = 2 ** QUEUE_ADDR_BITS;

  replay_pkg::writer_state_e state;
  replay_pkg::writer_state_e state_next;

  logic [replay_pkg::QID_BITS-1:0] cur_qid;
  logic [replay_pkg::QID_BITS-1:0] wr_qid;
  logic [PTR_BITS-1:0]             tail_q [replay_pkg::NUM_QUEUES];
  logic [PTR_BITS-1:0]             head_sel;
  logic [PTR_BITS-1:0]             ptr_diff;
  logic [PTR_BITS-1:0]             wr_ptr;
  logic [CNT_BITS-1:0]             used_words;
  logic [CNT_BITS-1:0]             free_words;
  logic                            pending_new;
  logic                            pending_cur;
  logic                            admit;
  logic                            store_word;

  // Queue of the write sitting in the output register
  assign wr_qid = mem_waddr[QUEUE_ADDR_BITS +: replay_pkg::QID_BITS];

  // A tail lags its registered write by one cycle, so count that write here
  assign pending_new = mem_we && (wr_qid == fifo_qid);
  assign pending_cur = mem_we && (wr_qid == cur_qid);

  // Free space of the queue named by the head word
  assign head_sel   = heads[fifo_qid*PTR_BITS +: PTR_BITS];
  assign ptr_diff   = tail_q[fifo_qid] - head_sel;
  assign used_words = {1'b0, ptr_diff} + {{(CNT_BITS-1){1'b0}}, pending_new};
  assign free_words = RING_WORDS[CNT_BITS-1:0] - used_words;
  assign admit      = (free_words >= MAX_PKT_WORDS[CNT_BITS-1:0]);

  // Next free slot of the packet being stored
  assign wr_ptr = tail_q[cur_qid] + {{QUEUE_ADDR_BITS{1'b0}}, pending_cur};

  assign store_word = (state == replay_pkg::W_WRITE) && fifo_rd_en;

  always_comb begin
    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      tails[q*PTR_BITS +: PTR_BITS] = tail_q[q];
    end
  end

  always_comb begin
    state_next = state;
    fifo_rd_en = 1'b0;
    case (state)
      replay_pkg::W_IDLE: begin
        if (!fifo_empty) begin
          state_next = admit ? replay_pkg::W_WRITE : replay_pkg::W_DROP;
        end
      end
      replay_pkg::W_WRITE, replay_pkg::W_DROP: begin
        // Pop every word, stored or not, until the packet ends
        if (!fifo_empty) begin
          fifo_rd_en = 1'b1;
          if (fifo_last) begin
            state_next = replay_pkg::W_IDLE;
          end
        end
      end
      default: begin
        state_next = replay_pkg::W_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= replay_pkg::W_IDLE;
      cur_qid <= '0;
      mem_we  <= 1'b0;
      for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
        tail_q[q] <= '0;
      end
    end else begin
      state  <= state_next;
      mem_we <= store_word;
      // Queue is fixed for the whole packet
      if ((state == replay_pkg::W_IDLE) && !fifo_empty) begin
        cur_qid <= fifo_qid;
      end
      // Tail moves on the edge that writes the word into memory
      if (mem_we) begin
        tail_q[wr_qid] <= tail_q[wr_qid] + 1'b1;
      end
    end
  end

  // Registered write port
  always_ff @(posedge clk) begin
    if (store_word) begin
      mem_waddr <= {cur_qid, wr_ptr[QUEUE_ADDR_BITS-1:0]};
      mem_wdata <= fifo_data;
    end
  end

endmodule

// ==== hw/replay_mem.sv ====
/*
 * Replay memory
 * Simple dual-port RAM holding all queue rings, registered read
 */
`timescale 1ns/1ns

module replay_mem #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_BITS  = 6
) (
  input  logic                  clk,
  input  logic                  we,
  input  logic [ADDR_BITS-1:0]  waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  re,
  input  logic [ADDR_BITS-1:0]  raddr,
  output logic [DATA_WIDTH-1:0] rdata
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  logic [DATA_WIDTH-1:0] ram [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      ram[waddr] <= wdata;
    end
  end

  // Read data holds between reads
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= ram[raddr];
    end
  end

endmodule

// ==== hw/ingress_fifo.sv ====
/*
 * Ingress FIFO
 * Show-ahead FIFO for packet words with their queue id and last flag
 */
`timescale 1ns/1ns

module ingress_fifo #(
  parameter int DATA_WIDTH     = 64,
  parameter int FIFO_ADDR_BITS = 3
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            wr_en,
  input  logic [DATA_WIDTH-1:0]           wr_data,
  input  logic [replay_pkg::QID_BITS-1:0] wr_qid,
  input  logic                            wr_last,
  output logic                            full,
  input  logic                            rd_en,
  output logic [DATA_WIDTH-1:0]           rd_data,
  output logic [replay_pkg::QID_BITS-1:0] rd_qid,
  output logic                            rd_last,
  output logic                            empty
);

  localparam int ENTRY_BITS = DATA_WIDTH + replay_pkg::QID_BITS + 1;
  localparam int DEPTH      = 2 ** FIFO_ADDR_BITS;

  // Entry layout is {last, qid, data}
  logic [ENTRY_BITS-1:0]   fifo_mem [DEPTH];
  logic [FIFO_ADDR_BITS:0] wr_ptr;
  logic [FIFO_ADDR_BITS:0] rd_ptr;
  logic [ENTRY_BITS-1:0]   head_entry;
  logic                    do_push;
  logic                    do_pop;

  // Same index with opposite wrap bits means full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS]) &&
                 (wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0]);

  assign do_push = wr_en && !full;
  assign do_pop  = rd_en && !empty;

  // Show-ahead read of the oldest entry
  assign head_entry = fifo_mem[rd_ptr[FIFO_ADDR_BITS-1:0]];
  assign rd_data    = head_entry[DATA_WIDTH-1:0];
  assign rd_qid     = head_entry[DATA_WIDTH +: replay_pkg::QID_BITS];
  assign rd_last    = head_entry[ENTRY_BITS-1];

  always_ff @(posedge clk) begin
    if (do_push) begin
      fifo_mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= {wr_last, wr_qid, wr_data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== hw/replay_pkg.sv ====
/*
 * Replay engine shared definitions
 * Queue count, queue id width and the queue writer FSM states
 */
package replay_pkg;

  // Four ring buffers, addressed by a 2-bit queue id
  localparam int NUM_QUEUES = 4;
  localparam int QID_BITS   = 2;

  // Queue writer FSM
  // W_IDLE waits for the first word of a packet and decides admit or drop
  // W_WRITE stores the packet, W_DROP discards it up to its last word
  typedef enum logic [1:0] {
    W_IDLE  = 2'd0,
    W_WRITE = 2'd1,
    W_DROP  = 2'd2
  } writer_state_e;

endpackage
